//--- files.f
src/isa_pkg.sv
src/uop_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/int_execute.sv
src/result_stage.sv
src/decode_core.sv
tests/core_checker.sv
tests/tb_decode_core.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_decode_core -f files.f \
	&& ./obj_dir/Vtb_decode_core | tee sim.log \
	&& grep -q "Simulation completed successfully" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

//--- src/decode_core.sv
// ============================
// Pipeline top: decoder, register file, execute
// and result stages
// ============================

module decode_core #(
	parameter bit HAS_MUL = 1'b1
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	output logic            in_ready,
	input  isa_pkg::instr_u in_instr,
	output logic            out_valid,
	input  logic            out_ready,
	output logic [4:0]      out_rd,
	output logic [31:0]     out_value,
	output logic            out_write,
	output logic            out_illegal
);

	// ============================
	// Stage interconnect
	// ============================
	logic             dec_valid;
	logic             dec_ready;
	uop_pkg::alu_op_e dec_op;
	logic [4:0]       dec_rd;
	logic [4:0]       dec_rs1;
	logic [4:0]       dec_rs2;
	logic [31:0]      dec_imm;
	logic             dec_use_imm;
	logic             dec_write;
	logic             dec_illegal;
	logic [31:0]      rs1_data;
	logic [31:0]      rs2_data;
	logic             ex_valid;
	logic             ex_ready;
	logic [4:0]       ex_rd;
	logic [31:0]      ex_value;
	logic             ex_write;
	logic             ex_illegal;
	logic             wr_en;
	logic [4:0]       wr_addr;
	logic [31:0]      wr_data;

	// Port names match the wires above, so the stages connect by name
	instr_decoder #(
		.HAS_MUL(HAS_MUL)
	) i_decoder (.*);

	// Source register fields from decode address the read ports directly
	reg_file i_reg_file (
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr_a(dec_rs1),
		.rd_addr_b(dec_rs2),
		.rd_data_a(rs1_data),
		.rd_data_b(rs2_data),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	int_execute i_execute (.*);

	result_stage i_result (.*);

endmodule

//--- src/instr_decoder.sv
// ============================
// Decode stage: input handshake, prefix latch, field
// extraction and the registered decode bus
// ============================

module instr_decoder #(
	parameter bit HAS_MUL = 1'b1
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	output logic             in_ready,
	input  isa_pkg::instr_u  in_instr,
	output logic             dec_valid,
	input  logic             dec_ready,
	output uop_pkg::alu_op_e dec_op,
	output logic [4:0]       dec_rd,
	output logic [4:0]       dec_rs1,
	output logic [4:0]       dec_rs2,
	output logic [31:0]      dec_imm,
	output logic             dec_use_imm,
	output logic             dec_write,
	output logic             dec_illegal
);

	logic             accept;
	logic             pfx_valid;
	logic [15:0]      pfx_hi;
	uop_pkg::alu_op_e op_d;
	logic             use_imm_d;
	logic             illegal_d;
	logic             nop_d;
	logic             is_pfx;
	logic [4:0]       rd_d;
	logic [4:0]       rs1_d;
	logic [31:0]      imm_d;
	logic             write_d;

	// The register takes a new word whenever its current item leaves or it is empty
	assign in_ready = !dec_valid || dec_ready;
	assign accept = in_valid && in_ready;

	// ============================
	// Opcode decode
	// ============================
	always_comb begin
		op_d = uop_pkg::ADD;
		use_imm_d = 1'b0;
		illegal_d = 1'b0;
		nop_d = 1'b0;
		is_pfx = 1'b0;
		case (in_instr.r.opcode)
			isa_pkg::NOP: nop_d = 1'b1;
			isa_pkg::ADD: op_d = uop_pkg::ADD;
			isa_pkg::SUB: op_d = uop_pkg::SUB;
			isa_pkg::AND: op_d = uop_pkg::AND;
			isa_pkg::OR:  op_d = uop_pkg::OR;
			isa_pkg::XOR: op_d = uop_pkg::XOR;
			isa_pkg::SHL: op_d = uop_pkg::SHL;
			isa_pkg::SHR: op_d = uop_pkg::SHR;
			isa_pkg::MUL: begin
				// Without a multiplier the code is treated as unknown
				if (HAS_MUL)
					op_d = uop_pkg::MUL;
				else
					illegal_d = 1'b1;
			end
			isa_pkg::ADDI: begin
				op_d = uop_pkg::ADD;
				use_imm_d = 1'b1;
			end
			isa_pkg::ANDI: begin
				op_d = uop_pkg::AND;
				use_imm_d = 1'b1;
			end
			isa_pkg::ORI: begin
				op_d = uop_pkg::OR;
				use_imm_d = 1'b1;
			end
			isa_pkg::XORI: begin
				op_d = uop_pkg::XOR;
				use_imm_d = 1'b1;
			end
			isa_pkg::PFX: is_pfx = 1'b1;
			default: illegal_d = 1'b1;
		endcase
	end

	// Register fields sit at the same bits in both views and are read through the R view
	assign rd_d = in_instr.r.rd;
	assign rs1_d = in_instr.r.rs1;

	// A pending prefix supplies the upper half, otherwise sign extend imm16
	assign imm_d = pfx_valid ? {pfx_hi, in_instr.i.imm16}
		: {{16{in_instr.i.imm16[15]}}, in_instr.i.imm16};

	// Writes to r0 are dropped here so the register file never sees them
	assign write_d = !illegal_d && !nop_d && !is_pfx && (rd_d != 5'd0);

	// ============================
	// Prefix latch and decode register
	// ============================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pfx_valid <= 1'b0;
		end else if (accept) begin
			// Any accepted non-prefix word consumes the prefix
			pfx_valid <= is_pfx;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && is_pfx)
			pfx_hi <= in_instr.i.imm16;
	end

	// A prefix word is swallowed and leaves the stage empty
	always_ff @(posedge clk) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else if (in_ready)
			dec_valid <= in_valid && !is_pfx;
	end

	// Payload holds while execute stalls
	always_ff @(posedge clk) begin
		if (accept) begin
			dec_op <= op_d;
			dec_rd <= rd_d;
			dec_rs1 <= rs1_d;
			dec_rs2 <= in_instr.r.rs2;
			dec_imm <= imm_d;
			dec_use_imm <= use_imm_d;
			dec_write <= write_d;
			dec_illegal <= illegal_d;
		end
	end

endmodule

//--- src/int_execute.sv
// ============================
// Execute stage: operand select, ALU and multiplier,
// purely combinational
// ============================

module int_execute (
	input  logic             dec_valid,
	output logic             dec_ready,
	input  uop_pkg::alu_op_e dec_op,
	input  logic [4:0]       dec_rd,
	input  logic [31:0]      dec_imm,
	input  logic             dec_use_imm,
	input  logic             dec_write,
	input  logic             dec_illegal,
	input  logic [31:0]      rs1_data,
	input  logic [31:0]      rs2_data,
	output logic             ex_valid,
	input  logic             ex_ready,
	output logic [4:0]       ex_rd,
	output logic [31:0]      ex_value,
	output logic             ex_write,
	output logic             ex_illegal
);

	logic [31:0] op_b;
	logic [31:0] result;

	// The stage holds no state, so handshake and tags pass straight across
	assign ex_valid = dec_valid;
	assign dec_ready = ex_ready;
	assign ex_rd = dec_rd;
	assign ex_write = dec_write;
	assign ex_illegal = dec_illegal;

	// Immediate formats replace the second register operand
	assign op_b = dec_use_imm ? dec_imm : rs2_data;

	always_comb begin
		case (dec_op)
			uop_pkg::ADD: result = rs1_data + op_b;
			uop_pkg::SUB: result = rs1_data - op_b;
			uop_pkg::AND: result = rs1_data & op_b;
			uop_pkg::OR:  result = rs1_data | op_b;
			uop_pkg::XOR: result = rs1_data ^ op_b;
			// Shift amount is masked to the low five bits
			uop_pkg::SHL: result = rs1_data << op_b[4:0];
			uop_pkg::SHR: result = rs1_data >> op_b[4:0];
			// Only the low word of the product is kept
			uop_pkg::MUL: result = rs1_data * op_b;
			default: result = '0;
		endcase
	end

	// Illegal words retire with a zero value
	assign ex_value = dec_illegal ? 32'd0 : result;

endmodule

//--- src/isa_pkg.sv
// ============================
// Instruction set definitions: opcode values, the two
// instruction word formats and the union that overlays them
// ============================

package isa_pkg;

	// Architectural register count and data width
	localparam int NUM_REGS = 32;
	localparam int XLEN = 32;

	// Opcode field in bits 31 to 26 of every word
	// Codes not listed here decode as illegal
	typedef enum logic [5:0] {
		NOP  = 6'h00,
		ADD  = 6'h01,
		SUB  = 6'h02,
		AND  = 6'h03,
		OR   = 6'h04,
		XOR  = 6'h05,
		SHL  = 6'h06,
		SHR  = 6'h07,
		MUL  = 6'h08,
		ADDI = 6'h10,
		ANDI = 6'h11,
		ORI  = 6'h12,
		XORI = 6'h13,
		PFX  = 6'h3F
	} opcode_e;

	// Register format with three register fields and a spare tail
	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [10:0] unused;
	} r_format_t;

	// Immediate format whose low half carries a 16-bit immediate
	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [15:0] imm16;
	} i_format_t;

	// One instruction word seen through either format
	typedef union packed {
		r_format_t r;
		i_format_t i;
	} instr_u;

endpackage

//--- src/reg_file.sv
// ============================
// Architectural register file, two combinational
// read ports and one write port
// ============================

module reg_file (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rd_addr_a,
	input  logic [4:0]  rd_addr_b,
	output logic [31:0] rd_data_a,
	output logic [31:0] rd_data_b,
	input  logic        wr_en,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data
);

	logic [isa_pkg::XLEN-1:0] regs [isa_pkg::NUM_REGS];

	// Register 0 is never a write target, so clearing it once keeps it zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < isa_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Reads see a write once its edge has passed, which removes any need to forward
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

//--- src/result_stage.sv
// ============================
// Result stage: output register, register-file write
// and output handshake
// ============================

module result_stage (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        ex_valid,
	output logic        ex_ready,
	input  logic [4:0]  ex_rd,
	input  logic [31:0] ex_value,
	input  logic        ex_write,
	input  logic        ex_illegal,
	output logic        wr_en,
	output logic [4:0]  wr_addr,
	output logic [31:0] wr_data,
	output logic        out_valid,
	input  logic        out_ready,
	output logic [4:0]  out_rd,
	output logic [31:0] out_value,
	output logic        out_write,
	output logic        out_illegal
);

	logic capture;

	// Space is free when the register is empty or being drained this cycle
	assign ex_ready = !out_valid || out_ready;
	assign capture = ex_valid && ex_ready;

	// The write commits on the capture edge, ahead of the output handshake
	assign wr_en = capture && ex_write;
	assign wr_addr = ex_rd;
	assign wr_data = ex_value;

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (ex_ready)
			out_valid <= ex_valid;
	end

	// Held stable while the consumer stalls
	always_ff @(posedge clk) begin
		if (capture) begin
			out_rd <= ex_rd;
			out_value <= ex_value;
			out_write <= ex_write;
			out_illegal <= ex_illegal;
		end
	end

endmodule

//--- src/uop_pkg.sv
// ============================
// Micro-operation encoding shared by decode, execute
// and result stages
// ============================

package uop_pkg;

	// Operation the execute stage performs on operands a and b
	// ADD to XOR are plain two-operand logic and arithmetic
	// SHL and SHR shift a by the low five bits of b with zero fill
	// MUL keeps only the low word of the product
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		SHL = 4'd5,
		SHR = 4'd6,
		MUL = 4'd7
	} alu_op_e;

endpackage

//--- tests/core_checker.sv
// ==============================
// Reference model and scoreboard: predicts each
// retired item and checks the output stream
// ==============================

module core_checker #(
	parameter bit HAS_MUL = 1'b1
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  logic        in_ready,
	input  logic [31:0] in_instr,
	input  logic        out_valid,
	input  logic        out_ready,
	input  logic [4:0]  out_rd,
	input  logic [31:0] out_value,
	input  logic        out_write,
	input  logic        out_illegal,
	output int          errors,
	output int          checks,
	output int          pending
);

	timeunit 1ns;
	timeprecision 1ps;

	// Architectural state as the instruction rules define it
	logic [31:0]   model_regs [0:31];
	logic          pfx_valid;
	logic [15:0]   pfx_hi;
	// Expected items in input order, with the edge each word was accepted on
	logic [4:0]    exp_rd [$];
	logic [31:0]   exp_value [$];
	logic          exp_write [$];
	logic          exp_illegal [$];
	logic          exp_known [$];
	logic [11:0]   exp_cycle [$];
	// Edge counter and the out_ready level seen at each edge
	logic [11:0]   cyc;
	logic [4095:0] ready_hist;
	logic          stalled;
	logic [4:0]    held_rd;
	logic [31:0]   held_value;
	logic          held_write;
	logic          held_illegal;
	logic          exp_in_ready;

	initial begin
		errors = 0;
		checks = 0;
		pending = 0;
	end

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	// Executes one accepted word on the model and queues what it should retire
	task automatic predict(input logic [31:0] word);
		logic [5:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] value;
		logic        illegal;
		logic        known;
		logic        write;
		op = word[31:26];
		a = model_regs[word[20:16]];
		b = model_regs[word[15:11]];
		// A pending prefix provides the upper half of the immediate
		imm = pfx_valid ? {pfx_hi, word[15:0]} : {{16{word[15]}}, word[15:0]};
		value = 32'd0;
		illegal = 1'b0;
		known = 1'b1;
		if (op == 6'h3F) begin
			pfx_valid = 1'b1;
			pfx_hi = word[15:0];
		end else begin
			pfx_valid = 1'b0;
			// R-format codes 0x00 to 0x08, I-format codes 0x10 to 0x13
			case (op)
				// The value of a NOP is not defined, so it is not compared
				6'h00: known = 1'b0;
				6'h01: value = a + b;
				6'h02: value = a - b;
				6'h03: value = a & b;
				6'h04: value = a | b;
				6'h05: value = a ^ b;
				6'h06: value = a << b[4:0];
				6'h07: value = a >> b[4:0];
				6'h08: begin
					if (HAS_MUL)
						value = a * b;
					else
						illegal = 1'b1;
				end
				6'h10: value = a + imm;
				6'h11: value = a & imm;
				6'h12: value = a | imm;
				6'h13: value = a ^ imm;
				default: illegal = 1'b1;
			endcase
			write = !illegal && (op != 6'h00) && (word[25:21] != 5'd0);
			if (write)
				model_regs[word[25:21]] = value;
			exp_rd.push_back(word[25:21]);
			exp_value.push_back(value);
			exp_write.push_back(write);
			exp_illegal.push_back(illegal);
			exp_known.push_back(known);
			exp_cycle.push_back(cyc);
		end
	endtask

	// ==============================
	// Output side
	// ==============================
	task automatic compare_output();
		logic [11:0] acc;
		logic [11:0] latency;
		logic        known;
		if (exp_rd.size() == 0) begin
			$display("Output item for rd %0d appeared with no accepted word left to match",
				out_rd);
			errors++;
		end else begin
			acc = exp_cycle.pop_front();
			known = exp_known.pop_front();
			latency = cyc - acc;
			check_field("out_rd", 32'(out_rd), 32'(exp_rd.pop_front()));
			check_field("out_write", 32'(out_write), 32'(exp_write.pop_front()));
			check_field("out_illegal", 32'(out_illegal), 32'(exp_illegal.pop_front()));
			if (known)
				check_field("out_value", out_value, exp_value.pop_front());
			else
				void'(exp_value.pop_front());
			// Without back-pressure an item leaves exactly two edges after acceptance
			if (latency < 12'd2 || (latency > 12'd2 && ready_hist[acc + 12'd1]
					&& ready_hist[acc + 12'd2])) begin
				$display("Word accepted at edge %0d retired after %0d edges instead of 2",
					acc, latency);
				errors++;
			end
			checks++;
		end
	endtask

	// A stalled item has to stay exactly as it was
	task automatic check_hold();
		if (!out_valid) begin
			$display("ERROR: out_valid = 0x0 while stalled, expected 0x1");
			errors++;
		end else begin
			check_field("out_rd while stalled", 32'(out_rd), 32'(held_rd));
			check_field("out_value while stalled", out_value, held_value);
			check_field("out_write while stalled", 32'(out_write), 32'(held_write));
			check_field("out_illegal while stalled", 32'(out_illegal), 32'(held_illegal));
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			model_regs = '{default: 32'd0};
			pfx_valid = 1'b0;
			stalled = 1'b0;
			cyc = 12'd0;
			exp_rd.delete();
			exp_value.delete();
			exp_write.delete();
			exp_illegal.delete();
			exp_known.delete();
			exp_cycle.delete();
		end else begin
			cyc = cyc + 12'd1;
			ready_hist[cyc] = out_ready;
			// Items in flight sit in the output register or else in the decode register
			// Decode is full only when a held output leaves a second item behind it
			exp_in_ready = !out_valid || out_ready || (exp_rd.size() < 2);
			check_field("in_ready", 32'(in_ready), 32'(exp_in_ready));
			if (stalled)
				check_hold();
			if (out_valid && out_ready)
				compare_output();
			// Output is handled first since a word never retires on its own accept edge
			if (in_valid && in_ready)
				predict(in_instr);
			stalled = out_valid && !out_ready;
			held_rd = out_rd;
			held_value = out_value;
			held_write = out_write;
			held_illegal = out_illegal;
		end
		pending = exp_rd.size();
	end

endmodule

//--- tests/tb_decode_core.sv
// ==============================
// Testbench top: clock, reset, random instruction
// stimulus, timeout and the pipeline DUT
// ==============================

module tb_decode_core;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_WORDS = 400;
	localparam int TIMEOUT_CYCLES = NUM_WORDS * 4 + 100;
	localparam bit HAS_MUL = 1'b1;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic        in_ready;
	logic [31:0] in_instr;
	logic        out_valid;
	logic        out_ready;
	logic [4:0]  out_rd;
	logic [31:0] out_value;
	logic        out_write;
	logic        out_illegal;
	int          errors;
	int          checks;
	int          pending;
	int          cycle_count = 0;
	logic [31:0] seed;
	// Set after a prefix so that an immediate-format word follows it
	logic        pfx_follow;

	decode_core #(.HAS_MUL(HAS_MUL)) i_dut (.*);

	core_checker #(.HAS_MUL(HAS_MUL)) i_checker (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Linear congruential generator whose upper bits are the useful ones
	function automatic logic [31:0] rand32();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Registers are kept to r0..r7 so that dependencies and r0 targets are frequent
	function automatic logic [31:0] random_word();
		logic [31:0] r;
		logic [31:0] low;
		logic [4:0]  sel;
		logic [5:0]  op;
		r = rand32();
		low = rand32();
		sel = r[20:16];
		if (pfx_follow) begin
			op = {4'b0100, r[15:14]};
			pfx_follow = 1'b0;
		end else if (sel < 5'd14) begin
			op = {3'b000, sel[2:0]} + 6'd1;
		end else if (sel < 5'd22) begin
			op = {4'b0100, sel[1:0]};
		end else if (sel < 5'd25) begin
			op = 6'h3F;
			pfx_follow = 1'b1;
		end else if (sel < 5'd27) begin
			op = 6'h00;
		end else begin
			case (sel)
				5'd27: op = 6'h09;
				5'd28: op = 6'h0F;
				5'd29: op = 6'h14;
				5'd30: op = 6'h2A;
				default: op = 6'h3E;
			endcase
		end
		// The low half is imm16 for I-format and prefix words, rs2 and spare bits otherwise
		if (op[5:4] != 2'b00)
			return {op, 2'b00, r[31:29], 2'b00, r[28:26], low[31:16]};
		return {op, 2'b00, r[31:29], 2'b00, r[28:26], 2'b00, r[25:23], low[10:0]};
	endfunction

	task automatic finish_run(input bit timed_out);
		if (timed_out)
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		if (pending != 0)
			$display("%0d expected results were never retired by the DUT", pending);
		$display("Results checked: %0d, errors: %0d, unmatched: %0d", checks, errors, pending);
		if (!timed_out && errors == 0 && pending == 0 && checks > 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	// ==============================
	// Stimulus
	// ==============================
	initial begin : stimulus
		int          sent;
		bit          drained;
		logic [31:0] r;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = 32'd0;
		out_ready = 1'b1;
		seed = 32'd1721;
		pfx_follow = 1'b0;
		sent = 0;
		drained = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		while (sent < NUM_WORDS) begin
			@(posedge clk);
			if (in_valid && in_ready)
				sent++;
			// A word on offer stays put until it is taken
			if (!in_valid || in_ready) begin
				r = rand32();
				if (sent < NUM_WORDS && r[31:30] != 2'b00) begin
					in_instr <= random_word();
					in_valid <= 1'b1;
				end else begin
					in_valid <= 1'b0;
				end
			end
			r = rand32();
			out_ready <= (r[31:30] != 2'b00);
		end
		// Keep stalling at random while the pipeline drains
		while (!drained) begin
			@(posedge clk);
			r = rand32();
			out_ready <= (r[31:30] != 2'b00);
			@(negedge clk);
			drained = (pending == 0);
		end
		@(posedge clk);
		out_ready <= 1'b1;
		// A few idle edges let any duplicated item show up
		repeat (4) @(posedge clk);
		@(negedge clk);
		finish_run(1'b0);
	end

	initial begin : watchdog
		wait (cycle_count >= TIMEOUT_CYCLES);
		@(negedge clk);
		finish_run(1'b1);
	end

endmodule
